//--- rtl/sv39_pkg.sv
// ----------------------------------------------------------
// Sv39 address and page-table-entry definitions shared by
// the page-table walker blocks. Import it inside a module
// body, or use scoped names in a port list.
// ----------------------------------------------------------

package sv39_pkg;

  // address and field widths
  localparam int unsigned VLEN          = 39;
  localparam int unsigned PLEN          = 56;
  localparam int unsigned PPN_W         = 44;
  localparam int unsigned VPN_W         = 9;
  localparam int unsigned PAGE_OFFSET_W = 12;

  typedef logic [VLEN-1:0] vaddr_t;
  typedef logic [PLEN-1:0] paddr_t;

  // page-table entry, bit 0 is v
  typedef struct packed {
    logic [9:0]       reserved;
    logic [PPN_W-1:0] ppn;
    logic [1:0]       rsw;
    logic             d;
    logic             a;
    logic             g;
    logic             u;
    logic             x;
    logic             w;
    logic             r;
    logic             v;
  } pte_t;

  // LVL1 is the root table and maps 1 GiB leaves
  typedef enum logic [1:0] {
    LVL1,
    LVL2,
    LVL3
  } ptw_lvl_e;

  // result of checking one fetched entry
  typedef enum logic [1:0] {
    PTE_POINTER,
    PTE_LEAF,
    PTE_FAULT
  } pte_kind_e;

endpackage

//--- rtl/ptw_bus_pkg.sv
// ----------------------------------------------------------
// Bus and handshake structs passed between the walker blocks:
// the Wishbone master and slave sides, the walk request held
// for a TLB miss, and the update written back to a TLB.
// ----------------------------------------------------------

package ptw_bus_pkg;

  // widest ASID a request can carry, narrower ones are zero-extended
  localparam int unsigned ASID_MAX = 16;

  // Wishbone classic, master to slave
  typedef struct packed {
    logic             cyc;
    logic             stb;
    logic             we;
    sv39_pkg::paddr_t adr;
    logic [7:0]       sel;
  } wb_m2s_t;

  // Wishbone classic, slave to master
  typedef struct packed {
    logic        ack;
    logic [63:0] dat;
  } wb_s2m_t;

  // one pending miss
  typedef struct packed {
    sv39_pkg::vaddr_t    vaddr;
    logic                is_instr;
    logic                is_store;
    logic [ASID_MAX-1:0] asid;
  } walk_req_t;

  // entry written into the ITLB or DTLB
  typedef struct packed {
    logic                valid;
    logic [26:0]         vpn;
    logic                is_2m;
    logic                is_1g;
    logic [ASID_MAX-1:0] asid;
    sv39_pkg::pte_t      content;
  } tlb_update_t;

endpackage

//--- rtl/ptw_miss_arbiter.sv
// ----------------------------------------------------------
// Input side of the walker. Picks one TLB miss, DTLB first,
// and holds it as a walk request until the walk controller
// takes it. Also pulses the per-TLB miss counters.
// ----------------------------------------------------------

`timescale 1ns/100ps

module ptw_miss_arbiter #(
  parameter int unsigned ASID_WIDTH = 16
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   flush_i,
  input  logic                   itlb_miss_i,
  input  ptw_bus_pkg::walk_req_t itlb_req_i,
  input  logic                   dtlb_miss_i,
  input  ptw_bus_pkg::walk_req_t dtlb_req_i,
  input  logic                   req_ready_i,
  output logic                   req_valid_o,
  output ptw_bus_pkg::walk_req_t req_o,
  output logic                   itlb_miss_o,
  output logic                   dtlb_miss_o
);
  import ptw_bus_pkg::*;

  walk_req_t           req_q;
  walk_req_t           pick;
  logic                valid_q;
  logic                fill;
  logic [ASID_MAX-1:0] asid_mask;

  // keeps only the ASID bits this core implements
  assign asid_mask = {ASID_MAX{1'b1}} >> (ASID_MAX - ASID_WIDTH);

  // load only while empty, a miss seen while full is dropped
  assign fill = !valid_q && !flush_i && (itlb_miss_i || dtlb_miss_i);

  always_comb begin
    // dtlb has priority
    pick      = dtlb_miss_i ? dtlb_req_i : itlb_req_i;
    pick.asid = pick.asid & asid_mask;
  end

  // ----------------------------------------------------------
  // control state
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q     <= 1'b0;
      itlb_miss_o <= 1'b0;
      dtlb_miss_o <= 1'b0;
    end else begin
      // counter pulses line up with the first cycle of req_valid_o
      itlb_miss_o <= fill && !dtlb_miss_i;
      dtlb_miss_o <= fill && dtlb_miss_i;
      if (flush_i || (valid_q && req_ready_i)) begin
        valid_q <= 1'b0;
      end else if (fill) begin
        valid_q <= 1'b1;
      end
    end
  end

  // request payload
  always_ff @(posedge clk_i) begin
    if (fill) begin
      req_q <= pick;
    end
  end

  assign req_valid_o = valid_q;
  assign req_o       = req_q;

endmodule

//--- rtl/ptw_walk_ctrl.sv
// ----------------------------------------------------------
// Walk FSM of the page-table walker. Takes one request, reads
// entries over a Wishbone classic master port, descends the
// three Sv39 levels on pointer entries and reports a done
// pulse with the final entry. The PTE checker classifies the
// entry in the ack cycle, so the next bus cycle or the done
// pulse follows one cycle after each ack.
// ----------------------------------------------------------

`timescale 1ns/100ps

module ptw_walk_ctrl (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         flush_i,
  input  logic [sv39_pkg::PPN_W-1:0]   satp_ppn_i,
  input  logic                         req_valid_i,
  input  ptw_bus_pkg::walk_req_t       req_i,
  output logic                         req_ready_o,
  output ptw_bus_pkg::wb_m2s_t         wb_o,
  input  ptw_bus_pkg::wb_s2m_t         wb_i,
  input  sv39_pkg::pte_kind_e          kind_i,
  output sv39_pkg::pte_t               pte_o,
  output sv39_pkg::ptw_lvl_e           lvl_o,
  output logic                         done_o,
  output logic                         done_leaf_o,
  output logic                         done_fault_o,
  output ptw_bus_pkg::walk_req_t       done_req_o,
  output logic                         active_o
);
  import sv39_pkg::*;
  import ptw_bus_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    BUS_CYCLE,
    EVALUATE,
    DRAIN
  } state_e;

  state_e           state_q, state_d;
  ptw_lvl_e         lvl_q, lvl_d;
  paddr_t           pptr_q, pptr_d;
  pte_t             pte_q;
  pte_t             fetched;
  walk_req_t        req_q;
  logic             global_q;
  logic             accept;
  logic             ack;
  logic             bus_busy;
  logic [VPN_W-1:0] next_vpn;

  // no new walk is taken in the flush cycle
  assign req_ready_o = (state_q == IDLE) && !flush_i;
  assign accept      = req_valid_i && req_ready_o;
  assign ack         = wb_i.ack && (state_q == BUS_CYCLE);

  // a global pointer makes every mapping below it global
  always_comb begin
    fetched   = pte_t'(wb_i.dat);
    fetched.g = fetched.g | global_q;
  end

  // live bus data in the ack cycle, held entry while reporting
  assign pte_o = (state_q == EVALUATE) ? pte_q : fetched;

  // vpn slice that indexes the next table
  assign next_vpn = (lvl_q == LVL1) ? req_q.vaddr[29:21] : req_q.vaddr[20:12];

  // ----------------------------------------------------------
  // next state
  // ----------------------------------------------------------
  always_comb begin
    state_d = state_q;
    lvl_d   = lvl_q;
    pptr_d  = pptr_q;
    unique case (state_q)
      IDLE: begin
        if (accept) begin
          // root table from satp, indexed by vpn[2]
          state_d = BUS_CYCLE;
          lvl_d   = LVL1;
          pptr_d  = {satp_ppn_i, req_i.vaddr[38:30], 3'b000};
        end
      end
      BUS_CYCLE: begin
        if (flush_i) begin
          // an open cycle must still see its ack
          state_d = wb_i.ack ? IDLE : DRAIN;
        end else if (wb_i.ack) begin
          if (kind_i == PTE_POINTER) begin
            state_d = BUS_CYCLE;
            lvl_d   = (lvl_q == LVL1) ? LVL2 : LVL3;
            pptr_d  = {fetched.ppn, next_vpn, 3'b000};
          end else begin
            state_d = EVALUATE;
          end
        end
      end
      EVALUATE: begin
        state_d = IDLE;
      end
      DRAIN: begin
        if (wb_i.ack) begin
          state_d = IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= IDLE;
      lvl_q    <= LVL1;
      global_q <= 1'b0;
    end else begin
      state_q <= state_d;
      lvl_q   <= lvl_d;
      if (accept) begin
        global_q <= 1'b0;
      end else if (ack && (kind_i == PTE_POINTER)) begin
        global_q <= fetched.g;
      end
    end
  end

  // address, request and entry payload
  always_ff @(posedge clk_i) begin
    pptr_q <= pptr_d;
    if (accept) begin
      req_q <= req_i;
    end
    if (ack) begin
      pte_q <= fetched;
    end
  end

  // ----------------------------------------------------------
  // Wishbone master, read only, full 64-bit lanes
  // ----------------------------------------------------------
  assign bus_busy = (state_q == BUS_CYCLE) || (state_q == DRAIN);

  always_comb begin
    wb_o.cyc = bus_busy;
    wb_o.stb = bus_busy;
    wb_o.we  = 1'b0;
    wb_o.adr = pptr_q;
    wb_o.sel = 8'hFF;
  end

  // result report, dropped if a flush lands in this cycle
  assign done_o       = (state_q == EVALUATE) && !flush_i;
  assign done_leaf_o  = done_o && (kind_i == PTE_LEAF);
  assign done_fault_o = done_o && (kind_i == PTE_FAULT);
  assign done_req_o   = req_q;
  assign lvl_o        = lvl_q;
  assign active_o     = (state_q != IDLE);

endmodule

//--- rtl/pte_checker.sv
// ----------------------------------------------------------
// Classifies one fetched page-table entry as a pointer to
// the next level, a usable leaf or a page fault, following
// the Sv39 rules for the walk's level and access type.
// Purely combinational.
// ----------------------------------------------------------

`timescale 1ns/100ps

module pte_checker (
  input  sv39_pkg::pte_t      pte_i,
  input  sv39_pkg::ptw_lvl_e  lvl_i,
  input  logic                is_instr_i,
  input  logic                is_store_i,
  input  logic                mxr_i,
  output sv39_pkg::pte_kind_e kind_o
);
  import sv39_pkg::*;

  logic misaligned;

  // a superpage leaf must have zero low ppn slices
  always_comb begin
    unique case (lvl_i)
      LVL1:    misaligned = (pte_i.ppn[17:0] != '0);
      LVL2:    misaligned = (pte_i.ppn[8:0] != '0);
      default: misaligned = 1'b0;
    endcase
  end

  always_comb begin
    kind_o = PTE_POINTER;
    if (!pte_i.v || (pte_i.w && !pte_i.r)) begin
      // invalid, or the reserved write-only encoding
      kind_o = PTE_FAULT;
    end else if (pte_i.r || pte_i.x) begin
      kind_o = PTE_LEAF;
      if (is_instr_i) begin
        // fetch needs an executable page with a set
        if (!pte_i.x || !pte_i.a) begin
          kind_o = PTE_FAULT;
        end
      end else begin
        if (!pte_i.a) begin
          kind_o = PTE_FAULT;
        end
        // execute-only pages are readable under MXR
        if (!pte_i.r && !(pte_i.x && mxr_i)) begin
          kind_o = PTE_FAULT;
        end
      end
      // stores need w and d, d is software managed
      if (is_store_i && !(pte_i.w && pte_i.d)) begin
        kind_o = PTE_FAULT;
      end
      if (misaligned) begin
        kind_o = PTE_FAULT;
      end
    end else begin
      // pointer: a, d, u are reserved here
      if (pte_i.a || pte_i.d || pte_i.u) begin
        kind_o = PTE_FAULT;
      end
      // no table below the last level
      if (lvl_i == LVL3) begin
        kind_o = PTE_FAULT;
      end
    end
  end

endmodule

//--- rtl/ptw_tlb_update.sv
// ----------------------------------------------------------
// Output side of the walker. Registers a finished walk and
// turns it into a one-cycle update on the ITLB or DTLB, or
// into a one-cycle page fault pulse.
// ----------------------------------------------------------

`timescale 1ns/100ps

module ptw_tlb_update (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     done_i,
  input  logic                     leaf_i,
  input  logic                     fault_i,
  input  sv39_pkg::ptw_lvl_e       lvl_i,
  input  sv39_pkg::pte_t           pte_i,
  input  ptw_bus_pkg::walk_req_t   req_i,
  output ptw_bus_pkg::tlb_update_t itlb_update_o,
  output ptw_bus_pkg::tlb_update_t dtlb_update_o,
  output logic                     ptw_fault_o
);
  import sv39_pkg::*;
  import ptw_bus_pkg::*;

  tlb_update_t entry_q;
  logic        itlb_valid_q;
  logic        dtlb_valid_q;

  // valid pulses, steered by the walk's origin
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      itlb_valid_q <= 1'b0;
      dtlb_valid_q <= 1'b0;
      ptw_fault_o  <= 1'b0;
    end else begin
      itlb_valid_q <= done_i && leaf_i && req_i.is_instr;
      dtlb_valid_q <= done_i && leaf_i && !req_i.is_instr;
      ptw_fault_o  <= done_i && fault_i;
    end
  end

  // entry payload, shared by both TLB ports
  always_ff @(posedge clk_i) begin
    if (done_i && leaf_i) begin
      entry_q.valid   <= 1'b0;
      entry_q.vpn     <= req_i.vaddr[38:12];
      entry_q.is_2m   <= (lvl_i == LVL2);
      entry_q.is_1g   <= (lvl_i == LVL1);
      entry_q.asid    <= req_i.asid;
      // g already folds in any global pointer on the way down
      entry_q.content <= pte_i;
    end
  end

  always_comb begin
    itlb_update_o       = entry_q;
    itlb_update_o.valid = itlb_valid_q;
    dtlb_update_o       = entry_q;
    dtlb_update_o.valid = dtlb_valid_q;
  end

endmodule

//--- rtl/ptw_top.sv
// ----------------------------------------------------------
// Sv39 page-table walker top level. Serves ITLB and DTLB
// misses over a Wishbone classic master port and returns
// TLB updates or page faults. Sets the ASID width.
// ----------------------------------------------------------

`timescale 1ns/100ps

module ptw_top #(
  parameter int unsigned ASID_WIDTH = 16
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       flush_i,
  input  logic                       itlb_miss_i,
  input  ptw_bus_pkg::walk_req_t     itlb_req_i,
  input  logic                       dtlb_miss_i,
  input  ptw_bus_pkg::walk_req_t     dtlb_req_i,
  input  logic [sv39_pkg::PPN_W-1:0] satp_ppn_i,
  input  logic                       mxr_i,
  output ptw_bus_pkg::wb_m2s_t       wb_o,
  input  ptw_bus_pkg::wb_s2m_t       wb_i,
  output ptw_bus_pkg::tlb_update_t   itlb_update_o,
  output ptw_bus_pkg::tlb_update_t   dtlb_update_o,
  output logic                       ptw_fault_o,
  output logic                       ptw_active_o,
  output logic                       itlb_miss_o,
  output logic                       dtlb_miss_o
);
  import sv39_pkg::*;
  import ptw_bus_pkg::*;

  // arbiter to walker
  walk_req_t req;
  logic      req_valid;
  logic      req_ready;

  // walker to checker and update block
  pte_t      pte;
  ptw_lvl_e  lvl;
  pte_kind_e kind;
  walk_req_t done_req;
  logic      done;
  logic      done_leaf;
  logic      done_fault;

  ptw_miss_arbiter #(
    .ASID_WIDTH (ASID_WIDTH)
  ) u_miss_arbiter (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .flush_i     (flush_i),
    .itlb_miss_i (itlb_miss_i),
    .itlb_req_i  (itlb_req_i),
    .dtlb_miss_i (dtlb_miss_i),
    .dtlb_req_i  (dtlb_req_i),
    .req_ready_i (req_ready),
    .req_valid_o (req_valid),
    .req_o       (req),
    .itlb_miss_o (itlb_miss_o),
    .dtlb_miss_o (dtlb_miss_o)
  );

  ptw_walk_ctrl u_walk_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .flush_i      (flush_i),
    .satp_ppn_i   (satp_ppn_i),
    .req_valid_i  (req_valid),
    .req_i        (req),
    .req_ready_o  (req_ready),
    .wb_o         (wb_o),
    .wb_i         (wb_i),
    .kind_i       (kind),
    .pte_o        (pte),
    .lvl_o        (lvl),
    .done_o       (done),
    .done_leaf_o  (done_leaf),
    .done_fault_o (done_fault),
    .done_req_o   (done_req),
    .active_o     (ptw_active_o)
  );

  // checks use the access type of the walk in flight
  pte_checker u_pte_checker (
    .pte_i      (pte),
    .lvl_i      (lvl),
    .is_instr_i (done_req.is_instr),
    .is_store_i (done_req.is_store),
    .mxr_i      (mxr_i),
    .kind_o     (kind)
  );

  ptw_tlb_update u_tlb_update (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .done_i        (done),
    .leaf_i        (done_leaf),
    .fault_i       (done_fault),
    .lvl_i         (lvl),
    .pte_i         (pte),
    .req_i         (done_req),
    .itlb_update_o (itlb_update_o),
    .dtlb_update_o (dtlb_update_o),
    .ptw_fault_o   (ptw_fault_o)
  );

endmodule

//--- verif/ptw_assertions.sv
// ----------------------------------------------------------
// Protocol assertions for the page-table walker, bound to
// the top level. Checks the Wishbone master signals and the
// one-hot rule on the update and fault pulses.
// ----------------------------------------------------------

`timescale 1ns/100ps

module ptw_assertions (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  ptw_bus_pkg::wb_m2s_t wb_m_i,
  input  logic                 itlb_valid_i,
  input  logic                 dtlb_valid_i,
  input  logic                 fault_i,
  output int unsigned          fail_count_o
);
  // failure counts, one per property
  int unsigned stb_fails   = 0;
  int unsigned pulse_fails = 0;
  int unsigned we_fails    = 0;

  assign fail_count_o = stb_fails + pulse_fails + we_fails;

  // stb never without an open cycle
  stb_needs_cyc: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_m_i.stb |-> wb_m_i.cyc)
    else begin
      stb_fails++;
      $error("wishbone stb high without cyc");
    end

  // one result per cycle at most
  one_result: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0({itlb_valid_i, dtlb_valid_i, fault_i}))
    else begin
      pulse_fails++;
      $error("more than one of itlb update, dtlb update and fault high");
    end

  // read-only master
  never_write: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !wb_m_i.we)
    else begin
      we_fails++;
      $error("wishbone we high");
    end

endmodule

//--- verif/tb_ptw.sv
// ----------------------------------------------------------
// Testbench for the Sv39 page-table walker. Loads page tables
// and miss vectors from the test data file, answers Wishbone
// reads with random wait states and checks every TLB update,
// fault and flush against the expected columns.
// ----------------------------------------------------------

`timescale 1ns/100ps

module tb_ptw;
  import sv39_pkg::*;
  import ptw_bus_pkg::*;

  // ----------------------------------------------------------
  // data layout and limits
  // ----------------------------------------------------------
  localparam int VEC_BASE       = 64;
  localparam int NUM_VEC        = 12;
  localparam int TDATA_WORDS    = VEC_BASE + 2 * NUM_VEC;
  localparam int TIMEOUT_CYCLES = 200 * NUM_VEC + 20;
  localparam int FLUSH_QUIET    = 20;
  localparam logic [3:0] OP_ITLB  = 4'd0;
  localparam logic [3:0] OP_PAIR  = 4'd2;
  localparam logic [3:0] OP_FLUSH = 4'd3;
  localparam logic [1:0] EV_ITLB  = 2'd0;
  localparam logic [1:0] EV_DTLB  = 2'd1;
  localparam logic [1:0] EV_FAULT = 2'd2;

  logic               clk_i = 1'b0;
  logic               rst_ni;
  logic               flush_i;
  logic               itlb_miss_i;
  logic               dtlb_miss_i;
  walk_req_t          itlb_req_i;
  walk_req_t          dtlb_req_i;
  logic [PPN_W-1:0]   satp_ppn_i;
  logic               mxr_i;
  wb_m2s_t            wb_m;
  wb_s2m_t            wb_s = '0;
  tlb_update_t        itlb_update_o;
  tlb_update_t        dtlb_update_o;
  logic               ptw_fault_o;
  logic               ptw_active_o;
  logic               itlb_miss_o;
  logic               dtlb_miss_o;

  logic [63:0] tdata [0:TDATA_WORDS-1];
  logic [31:0] rnd_state = 32'h78ef;
  logic [1:0]  wait_left;
  int          cycle_count = 0;

  // results seen by the monitor
  int          n_events    = 0;
  int          n_itlb_miss = 0;
  int          n_dtlb_miss = 0;
  logic [1:0]  ev_kind;
  tlb_update_t ev_upd;

  always #5 clk_i = ~clk_i;

  ptw_top #(
    .ASID_WIDTH (16)
  ) uut (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .flush_i       (flush_i),
    .itlb_miss_i   (itlb_miss_i),
    .itlb_req_i    (itlb_req_i),
    .dtlb_miss_i   (dtlb_miss_i),
    .dtlb_req_i    (dtlb_req_i),
    .satp_ppn_i    (satp_ppn_i),
    .mxr_i         (mxr_i),
    .wb_o          (wb_m),
    .wb_i          (wb_s),
    .itlb_update_o (itlb_update_o),
    .dtlb_update_o (dtlb_update_o),
    .ptw_fault_o   (ptw_fault_o),
    .ptw_active_o  (ptw_active_o),
    .itlb_miss_o   (itlb_miss_o),
    .dtlb_miss_o   (dtlb_miss_o)
  );

  bind ptw_top ptw_assertions u_ptw_assertions (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .wb_m_i       (wb_o),
    .itlb_valid_i (itlb_update_o.valid),
    .dtlb_valid_i (dtlb_update_o.valid),
    .fault_i      (ptw_fault_o),
    .fail_count_o ()
  );

  function automatic logic [31:0] next_random(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // request fields straight from a vector word
  function automatic walk_req_t make_req(input logic [63:0] vec, input logic is_instr);
    walk_req_t req;
    req.vaddr    = vec[38:0];
    req.is_instr = is_instr;
    req.is_store = vec[59];
    req.asid     = vec[55:40];
    return req;
  endfunction

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("TB FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      stop_with_error($sformatf("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  // ----------------------------------------------------------
  // wishbone slave, 0 to 3 wait states, one-cycle ack
  // ----------------------------------------------------------
  always @(posedge clk_i) begin
    if (!rst_ni) begin
      wb_s.ack  <= 1'b0;
      wb_s.dat  <= '0;
      wait_left <= 2'd0;
    end else if (wb_s.ack) begin
      wb_s.ack  <= 1'b0;
      rnd_state = next_random(rnd_state);
      wait_left <= rnd_state[1:0];
    end else if (wb_m.cyc && wb_m.stb) begin
      // every read takes all eight byte lanes
      check_value("wb_o.sel", 64'(wb_m.sel), 64'hFF);
      if (wait_left != 2'd0) begin
        wait_left <= wait_left - 2'd1;
      end else if ((wb_m.adr[55:15] != '0) || (wb_m.adr[11:6] != '0)) begin
        stop_with_error($sformatf("walker read 0x%0h outside the table memory", wb_m.adr));
      end else begin
        wb_s.ack <= 1'b1;
        wb_s.dat <= tdata[{1'b0, wb_m.adr[14:12], wb_m.adr[5:3]}];
      end
    end
  end

  // results and miss pulses, sampled away from the active edge
  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (itlb_miss_o) begin
        n_itlb_miss <= n_itlb_miss + 1;
      end
      if (dtlb_miss_o) begin
        n_dtlb_miss <= n_dtlb_miss + 1;
      end
      if (itlb_update_o.valid) begin
        ev_kind  <= EV_ITLB;
        ev_upd   <= itlb_update_o;
        n_events <= n_events + 1;
      end else if (dtlb_update_o.valid) begin
        ev_kind  <= EV_DTLB;
        ev_upd   <= dtlb_update_o;
        n_events <= n_events + 1;
      end else if (ptw_fault_o) begin
        ev_kind  <= EV_FAULT;
        n_events <= n_events + 1;
      end
    end
    if (uut.u_ptw_assertions.fail_count_o != 0) begin
      stop_with_error("a bound protocol assertion failed");
    end
  end

  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      stop_with_error($sformatf("walks did not finish within %0d cycles", TIMEOUT_CYCLES));
    end
  end

  // one-cycle miss pulses on either or both TLB ports
  task automatic drive_misses(input logic do_i, input logic [63:0] ia,
                              input logic do_d, input logic [63:0] da, input logic mxr);
    @(posedge clk_i);
    mxr_i       <= mxr;
    itlb_miss_i <= do_i;
    itlb_req_i  <= make_req(ia, 1'b1);
    dtlb_miss_i <= do_d;
    dtlb_req_i  <= make_req(da, 1'b0);
    @(posedge clk_i);
    itlb_miss_i <= 1'b0;
    dtlb_miss_i <= 1'b0;
  endtask

  task automatic wait_events(input int target);
    while (n_events < target) begin
      @(negedge clk_i);
    end
  endtask

  // expected update from the vector: vpn, size flags, asid, ppn, g
  task automatic check_result(input logic [63:0] va, input logic [63:0] ex, input logic instr);
    string port;
    port = instr ? "itlb_update_o" : "dtlb_update_o";
    if (ex[63]) begin
      check_value("ptw_fault_o", 64'(ev_kind), 64'(EV_FAULT));
    end else begin
      check_value({port, ".valid"}, 64'(ev_kind), 64'(instr ? EV_ITLB : EV_DTLB));
      check_value({port, ".vpn"}, 64'(ev_upd.vpn), 64'(va[38:12]));
      check_value({port, ".is_1g"}, 64'(ev_upd.is_1g), 64'(ex[61:60] == 2'd0));
      check_value({port, ".is_2m"}, 64'(ev_upd.is_2m), 64'(ex[61:60] == 2'd1));
      check_value({port, ".asid"}, 64'(ev_upd.asid), 64'(va[55:40]));
      check_value({port, ".content.ppn"}, 64'(ev_upd.content.ppn), 64'(ex[43:0]));
      check_value({port, ".content.g"}, 64'(ev_upd.content.g), 64'(ex[59]));
    end
  endtask

  task automatic run_single(input int idx);
    logic [63:0] va;
    logic [63:0] ex;
    logic        instr;
    int          ev_before;
    int          miss_before;
    va          = tdata[VEC_BASE + 2 * idx];
    ex          = tdata[VEC_BASE + 2 * idx + 1];
    instr       = (va[63:60] == OP_ITLB);
    ev_before   = n_events;
    miss_before = instr ? n_itlb_miss : n_dtlb_miss;
    drive_misses(instr, va, !instr, va, va[58]);
    wait_events(ev_before + 1);
    check_value(instr ? "itlb_miss_o count" : "dtlb_miss_o count",
                64'(instr ? n_itlb_miss : n_dtlb_miss), 64'(miss_before + 1));
    check_result(va, ex, instr);
  endtask

  // dtlb vector idx and itlb vector idx+1 in the same cycle
  task automatic run_pair(input int idx);
    logic [63:0] da;
    logic [63:0] dex;
    logic [63:0] ia;
    logic [63:0] iex;
    int          ev_before;
    int          i_before;
    int          d_before;
    da        = tdata[VEC_BASE + 2 * idx];
    dex       = tdata[VEC_BASE + 2 * idx + 1];
    ia        = tdata[VEC_BASE + 2 * idx + 2];
    iex       = tdata[VEC_BASE + 2 * idx + 3];
    ev_before = n_events;
    i_before  = n_itlb_miss;
    d_before  = n_dtlb_miss;
    drive_misses(1'b1, ia, 1'b1, da, da[58]);
    wait_events(ev_before + 1);
    check_value("dtlb_miss_o count", 64'(n_dtlb_miss), 64'(d_before + 1));
    check_value("itlb_miss_o count", 64'(n_itlb_miss), 64'(i_before));
    check_result(da, dex, 1'b0);
    // the dropped itlb miss comes back
    drive_misses(1'b1, ia, 1'b0, da, ia[58]);
    wait_events(ev_before + 2);
    check_value("itlb_miss_o count", 64'(n_itlb_miss), 64'(i_before + 1));
    check_result(ia, iex, 1'b1);
  endtask

  task automatic run_flush(input int idx);
    logic [63:0] va;
    int          ev_before;
    va        = tdata[VEC_BASE + 2 * idx];
    ev_before = n_events;
    drive_misses(1'b0, va, 1'b1, va, va[58]);
    @(negedge clk_i);
    while (!wb_m.cyc) begin
      @(negedge clk_i);
    end
    @(posedge clk_i);
    flush_i <= 1'b1;
    @(posedge clk_i);
    flush_i <= 1'b0;
    @(negedge clk_i);
    while (ptw_active_o) begin
      @(negedge clk_i);
    end
    repeat (FLUSH_QUIET) @(negedge clk_i);
    check_value("ptw_active_o", 64'(ptw_active_o), 64'd0);
    check_value("update and fault count", 64'(n_events), 64'(ev_before));
  endtask

  initial begin
    int vec;
    rst_ni      = 1'b0;
    flush_i     = 1'b0;
    itlb_miss_i = 1'b0;
    dtlb_miss_i = 1'b0;
    itlb_req_i  = '0;
    dtlb_req_i  = '0;
    satp_ppn_i  = 44'd1;
    mxr_i       = 1'b0;
    // unmapped words read as invalid entries tagged with their index
    for (int i = 0; i < TDATA_WORDS; i++) begin
      tdata[i] = 64'(i) << 10;
    end
    $readmemh("verif/ptw_testdata.txt", tdata);
    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;
    repeat (2) @(posedge clk_i);
    vec = 0;
    while (vec < NUM_VEC) begin
      case (tdata[VEC_BASE + 2 * vec][63:60])
        OP_PAIR: begin
          run_pair(vec);
          vec = vec + 2;
        end
        OP_FLUSH: begin
          run_flush(vec);
          vec = vec + 1;
        end
        default: begin
          run_single(vec);
          vec = vec + 1;
        end
      endcase
    end
    $display("TB PASSED");
    $finish;
  end

endmodule

//--- verif/ptw_testdata.txt
// page-table words at @00-@3F, index is {table ppn[2:0], vpn slice[2:0]}, satp ppn is 1
// vectors from @40, two words each: {op, store/mxr, asid, vaddr} then {fault, level, g, ppn}
// op 0 itlb, 1 dtlb, 2 dtlb issued with the next itlb vector, 3 flush during the walk
@08
0000000000000801
00000000100000E7
0000000000001001
0000000000001441
@10
0000000000000C01
@18
00000000002AF069
00000000048D144B
0000000000088847
00000000000CCC49
@20
000000000008044B
0000000000100043
@40
0000A50000001000 2000000000012345
1000010040000123 0800000000040000
1800020000002000 8000000000000000
1000030000003000 8000000000000000
1400040000003000 2000000000000333
1000050080000000 8000000000000000
1000060080200000 1000000000000400
10000700C0000000 8000000000000000
2000080000001000 2000000000012345
0000090000000000 2800000000000ABC
30000A0000001000 0000000000000000
00000B0000001000 2000000000012345

//--- tb.f
rtl/sv39_pkg.sv
rtl/ptw_bus_pkg.sv
rtl/ptw_miss_arbiter.sv
rtl/ptw_walk_ctrl.sv
rtl/pte_checker.sv
rtl/ptw_tlb_update.sv
rtl/ptw_top.sv
verif/ptw_assertions.sv
verif/tb_ptw.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the walker testbench with Verilator, run it, and look for the pass line.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_ptw -f tb.f -o tb_ptw_sim \
  && ./obj_dir/tb_ptw_sim +verilator+error+limit+100 | tee /dev/stderr | grep -q "TB PASSED" \
  && echo "simulation ok" \
  || { echo "simulation failed"; exit 1; }
